/* filelist.f */
+incdir+verif
design/kalman_pkg.sv
design/kalman_step_if.sv
design/kalman_sequencer.sv
design/kalman_addr_gen.sv
design/kalman_ram.sv
design/kalman_mac.sv
design/kalman_top.sv
verif/kalman_tb.sv

/* Makefile */
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall
SIM_FLAGS  = --binary --timing -Wno-fatal
TB_TOP     = kalman_tb
RTL_TOP    = kalman_top
FILELIST   = filelist.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/kalman_model.svh */
`ifndef KALMAN_MODEL_SVH
`define KALMAN_MODEL_SVH

// mirrors of both memories, updated in the order the DUT writes them
kalman_pkg::word_t st_mirror [512];
kalman_pkg::word_t cf_mirror [512];

// expected result port writes, oldest first
kalman_pkg::addr_t exp_addr_q [$];
kalman_pkg::word_t exp_data_q [$];

function automatic kalman_pkg::half_t hi_of(kalman_pkg::word_t w);
	return kalman_pkg::half_t'(w[35:18]);
endfunction

function automatic kalman_pkg::half_t lo_of(kalman_pkg::word_t w);
	return kalman_pkg::half_t'(w[17:0]);
endfunction

// a*b plus or minus c*d in Q17, shifted back and wrapped to 18 bits
function automatic kalman_pkg::half_t product_sum(kalman_pkg::half_t a, kalman_pkg::half_t b,
		kalman_pkg::half_t c, kalman_pkg::half_t d, logic subtract);
	logic signed [37:0] p;
	logic signed [37:0] q;
	logic signed [37:0] acc;
	p = 38'(a) * 38'(b);
	q = 38'(c) * 38'(d);
	acc = subtract ? p - q : p + q;
	return kalman_pkg::half_t'(acc >>> kalman_pkg::QMATH_SHIFT);
endfunction

function automatic void store_state(int addr, kalman_pkg::word_t data);
	st_mirror[addr] = data;
	exp_addr_q.push_back(kalman_pkg::addr_t'(addr));
	exp_data_q.push_back(data);
endfunction

// host writes into the state memory show up on the result port as well
function automatic void record_host_write(logic sel, kalman_pkg::addr_t addr,
		kalman_pkg::word_t data);
	if (sel)
		store_state(int'(addr), data);
	else
		cf_mirror[addr] = data;
endfunction

// one full run: predict, error and correct for every channel in turn
function automatic void predict_run();
	int blk;
	int xp_addr;
	kalman_pkg::word_t cf;
	kalman_pkg::half_t x1;
	kalman_pkg::half_t x2;
	kalman_pkg::half_t nx1;
	kalman_pkg::half_t nx2;
	kalman_pkg::half_t sum;
	kalman_pkg::half_t err;
	kalman_pkg::half_t amp;
	for (int n = 0; n < CHAN_NUM; n++) begin
		blk = n * CH_BLOCK;
		sum = '0;
		for (int h = 0; h < HARM_NUM; h++) begin
			xp_addr = blk + h * kalman_pkg::ST_WORDS_PER_HARM + kalman_pkg::ST_XP_OFS;
			x1 = hi_of(st_mirror[xp_addr]);
			x2 = lo_of(st_mirror[xp_addr]);
			cf = cf_mirror[h * kalman_pkg::CF_WORDS_PER_HARM + kalman_pkg::CF_CS_OFS];
			nx1 = product_sum(x1, hi_of(cf), x2, lo_of(cf), 1'b1);
			nx2 = product_sum(x1, lo_of(cf), x2, hi_of(cf), 1'b0);
			store_state(xp_addr, {nx1, nx2});
			sum = kalman_pkg::half_t'(sum + nx1);
		end
		err = kalman_pkg::half_t'(hi_of(cf_mirror[SAMPLE_OFS + n]) - sum);
		store_state(blk + SE_OFS, {sum, err});
		for (int h = 0; h < HARM_NUM; h++) begin
			xp_addr = blk + h * kalman_pkg::ST_WORDS_PER_HARM + kalman_pkg::ST_XP_OFS;
			x1 = hi_of(st_mirror[xp_addr]);
			x2 = lo_of(st_mirror[xp_addr]);
			amp = product_sum(x1, x1, x2, x2, 1'b0);
			store_state(blk + h * kalman_pkg::ST_WORDS_PER_HARM + kalman_pkg::ST_A_OFS,
				{kalman_pkg::half_t'(0), amp});
			cf = cf_mirror[h * kalman_pkg::CF_WORDS_PER_HARM + kalman_pkg::CF_K_OFS];
			nx1 = kalman_pkg::half_t'(x1 + product_sum(err, hi_of(cf), '0, '0, 1'b0));
			nx2 = kalman_pkg::half_t'(x2 + product_sum(err, lo_of(cf), '0, '0, 1'b0));
			store_state(xp_addr, {nx1, nx2});
		end
	end
endfunction

`endif

/* verif/kalman_tb.sv */
`timescale 1ns/10ps

module kalman_tb;

	localparam int HARM_NUM = 3;
	localparam int CHAN_NUM = 2;
	localparam int CH_BLOCK = kalman_pkg::ST_WORDS_PER_HARM * HARM_NUM + 1;
	localparam int SE_OFS = kalman_pkg::ST_WORDS_PER_HARM * HARM_NUM;
	localparam int SAMPLE_OFS = kalman_pkg::CF_WORDS_PER_HARM * HARM_NUM;
	localparam int CF_USED = SAMPLE_OFS + CHAN_NUM;
	localparam int ST_USED = CHAN_NUM * CH_BLOCK;
	localparam int STEPS_PER_RUN = CHAN_NUM * (3 * HARM_NUM + 1);
	localparam int RUN_TIMEOUT = STEPS_PER_RUN * 4 + 50;

	typedef struct packed {
		logic [4:0] mag_shift;
		logic [3:0] runs;
		logic reload;
	} row_t;

	// magnitude shift, runs, reload of states and coefficients
	localparam int NUM_ROWS = 4;
	localparam row_t STIM_ROWS [NUM_ROWS] = '{
		'{5'd3, 4'd1, 1'b1},
		'{5'd3, 4'd2, 1'b0},
		'{5'd6, 4'd1, 1'b1},
		'{5'd2, 4'd2, 1'b1}
	};

	logic clk_i;
	logic harmonics_rst;
	logic enable_i;
	logic host_we_i;
	logic host_sel_i;
	kalman_pkg::addr_t host_addr_i;
	kalman_pkg::word_t host_data_i;
	logic busy_o;
	logic res_we_o;
	kalman_pkg::addr_t res_addr_o;
	kalman_pkg::word_t res_data_o;

	logic [31:0] lfsr_q;
	int value_errors;
	int other_errors;
	int run_writes;

	`include "kalman_model.svh"

	kalman_top #(
		.HARMONICS_NUM(HARM_NUM),
		.CHANNELS(CHAN_NUM)
	) i_kalman_top (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.enable_i(enable_i),
		.host_we_i(host_we_i),
		.host_sel_i(host_sel_i),
		.host_addr_i(host_addr_i),
		.host_data_i(host_data_i),
		.busy_o(busy_o),
		.res_we_o(res_we_o),
		.res_addr_o(res_addr_o),
		.res_data_o(res_data_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// ########################################
	// random values and checks
	// ########################################

	// fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit
	function automatic logic [31:0] take_bits(int count);
		logic [31:0] bits;
		logic fb;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	function automatic kalman_pkg::half_t random_half(int shift);
		logic [31:0] raw;
		kalman_pkg::half_t v;
		raw = take_bits(18);
		v = kalman_pkg::half_t'(raw[17:0]);
		return v >>> shift;
	endfunction

	function automatic int total_steps();
		int n;
		n = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			n += int'(STIM_ROWS[r].runs) * STEPS_PER_RUN;
		return n;
	endfunction

	task automatic check_addr(string name, kalman_pkg::addr_t got, kalman_pkg::addr_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_word(string name, kalman_pkg::word_t got, kalman_pkg::word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_busy(logic exp);
		if (busy_o !== exp) begin
			value_errors++;
			$display("[FAIL] busy_o got %h expected %h at %0t", busy_o, exp, $time);
		end
	endtask

	task automatic check_we(logic exp);
		if (res_we_o !== exp) begin
			value_errors++;
			$display("[FAIL] res_we_o got %h expected %h at %0t", res_we_o, exp, $time);
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp) begin
			value_errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	// every result port pulse must match the oldest predicted write
	always @(posedge clk_i) begin
		kalman_pkg::addr_t exp_addr;
		kalman_pkg::word_t exp_data;
		if (!harmonics_rst && res_we_o === 1'b1) begin
			if (busy_o === 1'b1)
				run_writes++;
			if (exp_addr_q.size() == 0) begin
				other_errors++;
				$display("unexpected write on the result port to address %h at %0t",
					res_addr_o, $time);
			end else begin
				exp_addr = exp_addr_q.pop_front();
				exp_data = exp_data_q.pop_front();
				check_addr("res_addr_o", res_addr_o, exp_addr);
				check_word("res_data_o", res_data_o, exp_data);
			end
		end
	end

	initial begin
		int limit;
		limit = total_steps() * 10 + 500;
		repeat (limit) @(posedge clk_i);
		other_errors++;
		$display("watchdog expired after %0d cycles, the test did not finish", limit);
		$display("value mismatches %0d, other failures %0d", value_errors, other_errors);
		$display("Errors found");
		$finish;
	end

	// ########################################
	// host port and runs
	// ########################################

	task automatic host_write(logic sel, kalman_pkg::addr_t addr, kalman_pkg::word_t data);
		host_we_i = 1'b1;
		host_sel_i = sel;
		host_addr_i = addr;
		host_data_i = data;
		record_host_write(sel, addr, data);
		@(negedge clk_i);
	endtask

	task automatic load_memories(int shift);
		kalman_pkg::half_t hi;
		kalman_pkg::half_t lo;
		for (int a = 0; a < CF_USED; a++) begin
			hi = random_half(shift);
			lo = random_half(shift);
			host_write(1'b0, kalman_pkg::addr_t'(a), {hi, lo});
		end
		for (int a = 0; a < ST_USED; a++) begin
			hi = random_half(shift);
			lo = random_half(shift);
			host_write(1'b1, kalman_pkg::addr_t'(a), {hi, lo});
		end
		host_we_i = 1'b0;
		host_sel_i = 1'b0;
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (busy_o === 1'b1 && cycles < RUN_TIMEOUT) begin
			@(negedge clk_i);
			cycles++;
		end
		if (busy_o !== 1'b0) begin
			other_errors++;
			$display("busy_o did not fall within %0d cycles of the start", cycles);
		end
	endtask

	task automatic apply_run();
		predict_run();
		run_writes = 0;
		enable_i = 1'b1;
		@(negedge clk_i);
		enable_i = 1'b0;
		check_busy(1'b1);
		repeat (4) @(negedge clk_i);
		// a second start in the middle of a run has to be dropped
		enable_i = 1'b1;
		@(negedge clk_i);
		enable_i = 1'b0;
		wait_idle();
		check_count("run writes", run_writes, STEPS_PER_RUN);
		check_count("pending writes", exp_addr_q.size(), 0);
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	initial begin
		value_errors = 0;
		other_errors = 0;
		run_writes = 0;
		lfsr_q = 32'he138_cd7d;
		harmonics_rst = 1'b1;
		enable_i = 1'b0;
		host_we_i = 1'b0;
		host_sel_i = 1'b0;
		host_addr_i = '0;
		host_data_i = '0;
		repeat (3) @(negedge clk_i);
		harmonics_rst = 1'b0;

		// nothing may move after reset until a start
		repeat (6) begin
			@(negedge clk_i);
			check_busy(1'b0);
			check_we(1'b0);
		end

		for (int r = 0; r < NUM_ROWS; r++) begin
			check_busy(1'b0);
			if (STIM_ROWS[r].reload)
				load_memories(int'(STIM_ROWS[r].mag_shift));
			for (int k = 0; k < int'(STIM_ROWS[r].runs); k++)
				apply_run();
			repeat (2) @(negedge clk_i);
		end

		$display("value mismatches %0d, other failures %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* design/kalman_top.sv */
`timescale 1ns/10ps

module kalman_top #(
	parameter int HARMONICS_NUM = 26,
	parameter int CHANNELS = 3
) (
	input  logic clk_i,
	input  logic harmonics_rst,
	input  logic enable_i,
	input  logic host_we_i,
	input  logic host_sel_i,
	input  kalman_pkg::addr_t host_addr_i,
	input  kalman_pkg::word_t host_data_i,
	output logic busy_o,
	output logic res_we_o,
	output kalman_pkg::addr_t res_addr_o,
	output kalman_pkg::word_t res_data_o
);
	kalman_pkg::addr_t st_rd_addr;
	kalman_pkg::addr_t st_wr_addr;
	kalman_pkg::addr_t cf_rd_addr;
	kalman_pkg::word_t st_rd_data;
	kalman_pkg::word_t cf_rd_data;
	logic mac_we;
	kalman_pkg::addr_t mac_addr;
	kalman_pkg::word_t mac_data;
	logic st_we;
	kalman_pkg::addr_t st_addr;
	kalman_pkg::word_t st_data;
	logic cf_we;

	kalman_step_if #(
		.HARMONICS_NUM(HARMONICS_NUM),
		.CHANNELS(CHANNELS)
	) step_if ();

	// ########################################
	// control
	// ########################################

	kalman_sequencer #(
		.HARMONICS_NUM(HARMONICS_NUM),
		.CHANNELS(CHANNELS)
	) i_sequencer (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.enable_i(enable_i),
		.busy_o(busy_o),
		.step(step_if)
	);

	kalman_addr_gen #(
		.HARMONICS_NUM(HARMONICS_NUM),
		.CHANNELS(CHANNELS)
	) i_addr_gen (
		.clk_i(clk_i),
		.step(step_if),
		.st_rd_addr_o(st_rd_addr),
		.st_wr_addr_o(st_wr_addr),
		.cf_rd_addr_o(cf_rd_addr)
	);

	kalman_mac i_mac (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.step(step_if),
		.wr_addr_i(st_wr_addr),
		.st_data_i(st_rd_data),
		.cf_data_i(cf_rd_data),
		.wr_en_o(mac_we),
		.wr_addr_o(mac_addr),
		.wr_data_o(mac_data)
	);

	// ########################################
	// memories and host port
	// ########################################

	// the datapath owns the state write port for the whole run
	assign st_we = busy_o ? mac_we : (host_we_i && host_sel_i);
	assign st_addr = busy_o ? mac_addr : host_addr_i;
	assign st_data = busy_o ? mac_data : host_data_i;
	assign cf_we = host_we_i && !host_sel_i;

	kalman_ram state_ram (
		.clk_i(clk_i),
		.we_i(st_we),
		.wr_addr_i(st_addr),
		.wr_data_i(st_data),
		.rd_addr_i(st_rd_addr),
		.rd_data_o(st_rd_data)
	);

	kalman_ram coef_ram (
		.clk_i(clk_i),
		.we_i(cf_we),
		.wr_addr_i(host_addr_i),
		.wr_data_i(host_data_i),
		.rd_addr_i(cf_rd_addr),
		.rd_data_o(cf_rd_data)
	);

	assign res_we_o = st_we;
	assign res_addr_o = st_addr;
	assign res_data_o = st_data;

endmodule

/* design/kalman_mac.sv */
`timescale 1ns/10ps

module kalman_mac (
	input  logic clk_i,
	input  logic harmonics_rst,
	kalman_step_if.mac step,
	input  kalman_pkg::addr_t wr_addr_i,
	input  kalman_pkg::word_t st_data_i,
	input  kalman_pkg::word_t cf_data_i,
	output logic wr_en_o,
	output kalman_pkg::addr_t wr_addr_o,
	output kalman_pkg::word_t wr_data_o
);
	logic valid_d1;
	logic valid_d2;
	logic valid_d3;
	kalman_pkg::mac_op_e op_d1;
	kalman_pkg::mac_op_e op_d2;
	kalman_pkg::mac_op_e op_d3;
	kalman_pkg::addr_t waddr_d2;
	kalman_pkg::addr_t waddr_d3;
	kalman_pkg::half_t x1;
	kalman_pkg::half_t x2;
	kalman_pkg::half_t cf_hi;
	kalman_pkg::half_t cf_lo;
	kalman_pkg::half_t mul_a [4];
	kalman_pkg::half_t mul_b [4];
	kalman_pkg::prod_t prod_q [4];
	kalman_pkg::half_t base_hi_q;
	kalman_pkg::half_t base_lo_q;
	kalman_pkg::half_t sum_q;
	kalman_pkg::half_t err_q;
	logic signed [36:0] acc_hi;
	logic signed [36:0] acc_lo;
	kalman_pkg::half_t new_hi;
	kalman_pkg::half_t new_lo;

	// truncating shift back to Q17, the result wraps at 18 bits
	function automatic kalman_pkg::half_t qscale(logic signed [36:0] acc);
		return kalman_pkg::half_t'(acc[kalman_pkg::QMATH_SHIFT +: 18]);
	endfunction

	assign x1 = kalman_pkg::word_hi(st_data_i);
	assign x2 = kalman_pkg::word_lo(st_data_i);
	assign cf_hi = kalman_pkg::word_hi(cf_data_i);
	assign cf_lo = kalman_pkg::word_lo(cf_data_i);

	// ########################################
	// operand select, aligned with read data
	// ########################################

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			mul_a[i] = '0;
			mul_b[i] = '0;
		end
		case (op_d2)
			kalman_pkg::OP_ROTATE: begin
				mul_a[0] = x1;
				mul_b[0] = cf_hi;
				mul_a[1] = x2;
				mul_b[1] = cf_lo;
				mul_a[2] = x1;
				mul_b[2] = cf_lo;
				mul_a[3] = x2;
				mul_b[3] = cf_hi;
			end
			kalman_pkg::OP_AMP: begin
				mul_a[0] = x1;
				mul_b[0] = x1;
				mul_a[1] = x2;
				mul_b[1] = x2;
			end
			kalman_pkg::OP_CORRECT: begin
				mul_a[0] = err_q;
				mul_b[0] = cf_hi;
				mul_a[1] = err_q;
				mul_b[1] = cf_lo;
			end
			default: begin
				mul_a[0] = '0;
			end
		endcase
	end

	// ########################################
	// combine and scale
	// ########################################

	always_comb begin
		acc_hi = '0;
		acc_lo = '0;
		case (op_d3)
			kalman_pkg::OP_ROTATE: begin
				acc_hi = prod_q[0] - prod_q[1];
				acc_lo = prod_q[2] + prod_q[3];
			end
			kalman_pkg::OP_AMP: begin
				acc_lo = prod_q[0] + prod_q[1];
			end
			kalman_pkg::OP_CORRECT: begin
				acc_hi = prod_q[0];
				acc_lo = prod_q[1];
			end
			default: begin
				acc_hi = '0;
			end
		endcase
		new_hi = base_hi_q + qscale(acc_hi);
		new_lo = base_lo_q + qscale(acc_lo);
		// the error word has no products, just sum and sample minus sum
		if (op_d3 == kalman_pkg::OP_ERROR) begin
			new_hi = sum_q;
			new_lo = base_lo_q - sum_q;
		end
	end

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			valid_d1 <= 1'b0;
			valid_d2 <= 1'b0;
			valid_d3 <= 1'b0;
			wr_en_o <= 1'b0;
			sum_q <= '0;
			err_q <= '0;
		end else begin
			valid_d1 <= step.step_valid;
			valid_d2 <= valid_d1;
			valid_d3 <= valid_d2;
			wr_en_o <= valid_d3;
			if (valid_d3 && op_d3 == kalman_pkg::OP_ROTATE)
				sum_q <= sum_q + new_hi;
			if (valid_d3 && op_d3 == kalman_pkg::OP_ERROR) begin
				sum_q <= '0;
				err_q <= new_lo;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		op_d1 <= step.op;
		op_d2 <= op_d1;
		op_d3 <= op_d2;
		waddr_d2 <= wr_addr_i;
		waddr_d3 <= waddr_d2;
		for (int i = 0; i < 4; i++)
			prod_q[i] <= mul_a[i] * mul_b[i];
		base_hi_q <= (op_d2 == kalman_pkg::OP_CORRECT) ? x1 : '0;
		case (op_d2)
			kalman_pkg::OP_CORRECT: base_lo_q <= x2;
			kalman_pkg::OP_ERROR: base_lo_q <= cf_hi;
			default: base_lo_q <= '0;
		endcase
		wr_addr_o <= waddr_d3;
		wr_data_o <= kalman_pkg::pack_word(new_hi, new_lo);
	end

endmodule

/* design/kalman_ram.sv */
`timescale 1ns/10ps

module kalman_ram (
	input  logic clk_i,
	input  logic we_i,
	input  kalman_pkg::addr_t wr_addr_i,
	input  kalman_pkg::word_t wr_data_i,
	input  kalman_pkg::addr_t rd_addr_i,
	output kalman_pkg::word_t rd_data_o
);
	localparam int DEPTH = 2 ** $bits(kalman_pkg::addr_t);

	kalman_pkg::word_t mem [DEPTH];

	always_ff @(posedge clk_i) begin
		if (we_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// one cycle read latency, a write in the same cycle returns old data
	always_ff @(posedge clk_i) begin
		rd_data_o <= mem[rd_addr_i];
	end

endmodule

/* design/kalman_addr_gen.sv */
`timescale 1ns/10ps

module kalman_addr_gen #(
	parameter int HARMONICS_NUM = 26,
	parameter int CHANNELS = 3
) (
	input  logic clk_i,
	kalman_step_if.addr step,
	output kalman_pkg::addr_t st_rd_addr_o,
	output kalman_pkg::addr_t st_wr_addr_o,
	output kalman_pkg::addr_t cf_rd_addr_o
);
	localparam int HARM_W = (HARMONICS_NUM > 1) ? $clog2(HARMONICS_NUM) : 1;
	localparam int CH_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;
	localparam int SE_OFS = kalman_pkg::ST_WORDS_PER_HARM * HARMONICS_NUM;
	localparam int CH_BLOCK = SE_OFS + 1;
	localparam int IN_OFS = kalman_pkg::CF_WORDS_PER_HARM * HARMONICS_NUM;

	logic [CH_W-1:0] ch_idx;
	logic [HARM_W-1:0] harm_idx;
	kalman_pkg::addr_t st_harm;
	kalman_pkg::addr_t cf_harm;
	kalman_pkg::addr_t se_addr;
	kalman_pkg::addr_t in_addr;

	assign ch_idx = step.channel;
	assign harm_idx = step.harmonic;

	always_comb begin
		st_harm = kalman_pkg::addr_t'(ch_idx * CH_BLOCK + harm_idx * kalman_pkg::ST_WORDS_PER_HARM);
		cf_harm = kalman_pkg::addr_t'(harm_idx * kalman_pkg::CF_WORDS_PER_HARM);
		se_addr = kalman_pkg::addr_t'(ch_idx * CH_BLOCK + SE_OFS);
		in_addr = kalman_pkg::addr_t'(IN_OFS + ch_idx);
	end

	// addresses only move on a step, otherwise the rams see the last one
	always_ff @(posedge clk_i) begin
		if (step.step_valid) begin
			case (step.op)
				kalman_pkg::OP_ERROR: begin
					st_rd_addr_o <= se_addr;
					st_wr_addr_o <= se_addr;
					cf_rd_addr_o <= in_addr;
				end
				kalman_pkg::OP_AMP: begin
					// read the pair, write the amplitude next to it
					st_rd_addr_o <= st_harm + kalman_pkg::addr_t'(kalman_pkg::ST_XP_OFS);
					st_wr_addr_o <= st_harm + kalman_pkg::addr_t'(kalman_pkg::ST_A_OFS);
					cf_rd_addr_o <= cf_harm + kalman_pkg::addr_t'(kalman_pkg::CF_CS_OFS);
				end
				kalman_pkg::OP_CORRECT: begin
					st_rd_addr_o <= st_harm + kalman_pkg::addr_t'(kalman_pkg::ST_XP_OFS);
					st_wr_addr_o <= st_harm + kalman_pkg::addr_t'(kalman_pkg::ST_XP_OFS);
					cf_rd_addr_o <= cf_harm + kalman_pkg::addr_t'(kalman_pkg::CF_K_OFS);
				end
				default: begin
					st_rd_addr_o <= st_harm + kalman_pkg::addr_t'(kalman_pkg::ST_XP_OFS);
					st_wr_addr_o <= st_harm + kalman_pkg::addr_t'(kalman_pkg::ST_XP_OFS);
					cf_rd_addr_o <= cf_harm + kalman_pkg::addr_t'(kalman_pkg::CF_CS_OFS);
				end
			endcase
		end
	end

endmodule

/* design/kalman_sequencer.sv */
`timescale 1ns/10ps

module kalman_sequencer #(
	parameter int HARMONICS_NUM = 26,
	parameter int CHANNELS = 3
) (
	input  logic clk_i,
	input  logic harmonics_rst,
	input  logic enable_i,
	output logic busy_o,
	kalman_step_if.seq step
);
	localparam int HARM_W = (HARMONICS_NUM > 1) ? $clog2(HARMONICS_NUM) : 1;
	localparam int CH_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;
	// the sum and error registers need three spare cycles before use
	localparam int DRAIN_CYCLES = 3;
	localparam logic [2:0] DRAIN_LOAD = 3'(DRAIN_CYCLES - 1);
	localparam logic [2:0] FLUSH_LOAD = 3'(kalman_pkg::MAC_LATENCY - 1);

	typedef enum logic [2:0] {
		IDLE,
		ROTATE,
		DRAIN_SUM,
		ERROR,
		DRAIN_ERR,
		AMP,
		CORRECT,
		FLUSH
	} seq_state_e;

	seq_state_e state_q;
	logic [CH_W-1:0] ch_q;
	logic [HARM_W-1:0] harm_q;
	logic [2:0] wait_q;
	logic last_harm;
	logic last_ch;
	logic wait_done;

	assign last_harm = harm_q == HARM_W'(HARMONICS_NUM - 1);
	assign last_ch = ch_q == CH_W'(CHANNELS - 1);
	assign wait_done = wait_q == '0;

	// ########################################
	// state and counters
	// ########################################

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			state_q <= IDLE;
			ch_q <= '0;
			harm_q <= '0;
			wait_q <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					ch_q <= '0;
					harm_q <= '0;
					if (enable_i)
						state_q <= ROTATE;
				end
				ROTATE: begin
					if (last_harm) begin
						harm_q <= '0;
						wait_q <= DRAIN_LOAD;
						state_q <= DRAIN_SUM;
					end else begin
						harm_q <= harm_q + 1'b1;
					end
				end
				DRAIN_SUM: begin
					if (wait_done)
						state_q <= ERROR;
					else
						wait_q <= wait_q - 1'b1;
				end
				ERROR: begin
					wait_q <= DRAIN_LOAD;
					state_q <= DRAIN_ERR;
				end
				DRAIN_ERR: begin
					if (wait_done)
						state_q <= AMP;
					else
						wait_q <= wait_q - 1'b1;
				end
				AMP: begin
					state_q <= CORRECT;
				end
				CORRECT: begin
					if (!last_harm) begin
						harm_q <= harm_q + 1'b1;
						state_q <= AMP;
					end else if (last_ch) begin
						harm_q <= '0;
						ch_q <= '0;
						wait_q <= FLUSH_LOAD;
						state_q <= FLUSH;
					end else begin
						harm_q <= '0;
						ch_q <= ch_q + 1'b1;
						state_q <= ROTATE;
					end
				end
				FLUSH: begin
					// hold busy until the last write has left the datapath
					if (wait_done)
						state_q <= IDLE;
					else
						wait_q <= wait_q - 1'b1;
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// ########################################
	// step outputs
	// ########################################

	always_comb begin
		step.step_valid = 1'b0;
		step.op = kalman_pkg::OP_ROTATE;
		case (state_q)
			ROTATE: begin
				step.step_valid = 1'b1;
				step.op = kalman_pkg::OP_ROTATE;
			end
			ERROR: begin
				step.step_valid = 1'b1;
				step.op = kalman_pkg::OP_ERROR;
			end
			AMP: begin
				step.step_valid = 1'b1;
				step.op = kalman_pkg::OP_AMP;
			end
			CORRECT: begin
				step.step_valid = 1'b1;
				step.op = kalman_pkg::OP_CORRECT;
			end
			default: begin
				step.step_valid = 1'b0;
			end
		endcase
	end

	assign step.channel = ch_q;
	assign step.harmonic = harm_q;
	assign busy_o = state_q != IDLE;

endmodule

/* design/kalman_step_if.sv */
`timescale 1ns/10ps

interface kalman_step_if #(
	parameter int HARMONICS_NUM = 26,
	parameter int CHANNELS = 3
) ();
	localparam int HARM_W = (HARMONICS_NUM > 1) ? $clog2(HARMONICS_NUM) : 1;
	localparam int CH_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

	// one step per cycle while step_valid is high, no handshake
	logic step_valid;
	kalman_pkg::mac_op_e op;
	logic [CH_W-1:0] channel;
	logic [HARM_W-1:0] harmonic;

	modport seq (
		output step_valid,
		output op,
		output channel,
		output harmonic
	);

	modport addr (
		input step_valid,
		input op,
		input channel,
		input harmonic
	);

	// the datapath only needs to know what to do, not where
	modport mac (
		input step_valid,
		input op
	);

endinterface

/* design/kalman_pkg.sv */
package kalman_pkg;

	// ########################################
	// data words
	// ########################################

	// one memory word carries two 18-bit halves, high half first
	typedef logic [35:0] word_t;
	// signed fixed point with 17 fractional bits
	typedef logic signed [17:0] half_t;
	typedef logic [8:0] addr_t;
	// full 18x18 product before scaling
	typedef logic signed [35:0] prod_t;

	typedef enum logic [1:0] {
		OP_ROTATE,
		OP_ERROR,
		OP_AMP,
		OP_CORRECT
	} mac_op_e;

	// every product sum is brought back to Q17 by an arithmetic shift
	localparam int QMATH_SHIFT = 17;
	// cycles from a step on the sequencer to its state write
	localparam int MAC_LATENCY = 4;

	// ########################################
	// memory layout
	// ########################################

	// state block per channel: 2 words per harmonic, then the SE word
	localparam int ST_XP_OFS = 0;
	localparam int ST_A_OFS = 1;
	localparam int ST_WORDS_PER_HARM = 2;

	// coefficients are shared by all channels, input samples follow them
	localparam int CF_CS_OFS = 0;
	localparam int CF_K_OFS = 1;
	localparam int CF_WORDS_PER_HARM = 2;

	function automatic half_t word_hi(word_t w);
		return half_t'(w[35:18]);
	endfunction

	function automatic half_t word_lo(word_t w);
		return half_t'(w[17:0]);
	endfunction

	function automatic word_t pack_word(half_t hi, half_t lo);
		return {hi, lo};
	endfunction

endpackage
